//--- src/fetch_pkg.sv
package fetch_pkg;

    // branch history table geometry
    localparam int bht_entries = 256;
    localparam int bht_index_w = 8;

    // fetch packet queue slots
    localparam int fifo_depth = 4;

    // branch class of one slot or of a whole packet
    typedef enum logic [1:0] {
        none     = 2'b00,
        uncond   = 2'b01,
        pc_rel   = 2'b10,
        indirect = 2'b11
    } btype_e;

    // offset field layout of a branch word
    typedef struct packed {
        logic [5:0]  op6;
        logic [15:0] offs16;
        logic [9:0]  offs_hi10;
    } inst_fields_t;

    // raw view feeds the classifier, field view feeds the target guess
    typedef union packed {
        logic [31:0]  raw;
        inst_fields_t f;
    } inst_word_u;

    // one fetch packet, two words at pc and pc+4
    typedef struct packed {
        logic [31:0] pc;
        inst_word_u  inst0;
        inst_word_u  inst1;
    } fetch_pkt_t;

    typedef struct packed {
        logic        valid;
        btype_e      btype;
        logic [31:0] target;
    } bht_entry_t;

    // training write from the back end
    typedef struct packed {
        logic [bht_index_w-1:0] index;
        btype_e                 btype;
        logic [31:0]            target;
    } bht_update_t;

    typedef struct packed {
        logic [31:0]            pc;
        btype_e                 btype;
        logic [bht_index_w-1:0] index;
        logic [31:0]            target;
        logic                   hit;
        btype_e                 hist_btype;
        logic [31:0]            hist_target;
    } predecode_t;

endpackage

//--- src/fetch_fifo.sv
`timescale 1ns/1ps

module fetch_fifo
    import fetch_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       push,
    input  fetch_pkt_t push_pkt,
    input  logic       pop,
    input  logic       flush,
    output fetch_pkt_t head,
    output logic       empty,
    output logic       full
);

    // packet storage, no reset needed on payload
    fetch_pkt_t mem [fifo_depth];

    logic [$clog2(fifo_depth)-1:0] rd_ptr;
    logic [$clog2(fifo_depth)-1:0] wr_ptr;
    logic [$clog2(fifo_depth):0]   count;
    logic                          push_ok;
    logic                          pop_ok;

    assign empty = (count == '0);
    assign full  = (count == ($clog2(fifo_depth) + 1)'(fifo_depth));

    // push while full is simply dropped
    assign push_ok = push && !full;
    assign pop_ok  = pop && !empty;

    // head comes straight out of the array
    assign head = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push_ok)
            mem[wr_ptr] <= push_pkt;
    end

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_ok)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop_ok)
                rd_ptr <= rd_ptr + 1'b1;
            // simultaneous push and pop leaves count alone
            case ({push_ok, pop_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- src/fifo_predecoder.sv
`timescale 1ns/1ps

module fifo_predecoder
    import fetch_pkg::*;
(
    input  fetch_pkt_t             pkt,
    output btype_e                 btype,
    output logic [bht_index_w-1:0] index,
    output logic [31:0]            target
);

    // per-slot class from the opcode prefix
    function automatic btype_e classify(input inst_word_u w);
        if (w.raw[31:27] == 5'b01010 || w.raw[31:27] == 5'b01001)
            return uncond;
        else if (w.raw[31:27] == 5'b01011 || w.raw[31:28] == 4'b0110)
            return pc_rel;
        else if (w.raw[31:26] == 6'b010011)
            return indirect;
        else
            return none;
    endfunction

    btype_e      class0;
    btype_e      class1;
    logic        slot_sel;
    inst_word_u  slot_word;
    logic [31:0] slot_pc;
    logic [31:0] offs_long;
    logic [31:0] offs_short;

    assign class0 = classify(pkt.inst0);
    assign class1 = classify(pkt.inst1);

    // second slot wins whenever it branches
    assign slot_sel = (class1 != none);

    // packet type priority
    // pc[2] set means only slot 1 is live
    always_comb begin
        if (class1 != none)
            btype = class1;
        else if (pkt.pc[2])
            btype = none;
        else if (class0 == indirect)
            btype = indirect;
        else
            btype = none;
    end

    // index from scattered pc bits
    assign index = {pkt.pc[19], pkt.pc[16:12], pkt.pc[5:4]};

    assign slot_word = slot_sel ? pkt.inst1 : pkt.inst0;
    assign slot_pc   = {pkt.pc[31:3], slot_sel, 2'b00};

    // 26-bit offset, hi10 on top of offs16, word aligned
    assign offs_long = {{4{slot_word.f.offs_hi10[9]}}, slot_word.f.offs_hi10,
                        slot_word.f.offs16, 2'b00};
    assign offs_short = {{14{slot_word.f.offs16[15]}}, slot_word.f.offs16, 2'b00};

    // only a guess, indirect has no static target
    always_comb begin
        case (btype)
            uncond, pc_rel: begin
                if (slot_word.f.op6[5:1] == 5'b01010)
                    target = slot_pc + offs_long;
                else
                    target = slot_pc + offs_short;
            end
            default: target = '0;
        endcase
    end

endmodule

//--- src/branch_history_table.sv
`timescale 1ns/1ps

module branch_history_table
    import fetch_pkg::*;
(
    input  logic                   clk,
    input  logic [bht_index_w-1:0] rd_index,
    output bht_entry_t             rd_entry,
    input  logic                   wr_en,
    input  bht_update_t            wr,
    input  logic                   clearing,
    input  logic [bht_index_w-1:0] clear_addr
);

    // entry array, contents settled by the clear sweep
    bht_entry_t mem [bht_entries];

    // read is combinational, new writes seen next cycle
    assign rd_entry = mem[rd_index];

    // sweep has priority over training
    always_ff @(posedge clk) begin
        if (clearing) begin
            mem[clear_addr] <= '0;
        end else if (wr_en) begin
            mem[wr.index] <= '{valid: 1'b1, btype: wr.btype, target: wr.target};
        end
    end

endmodule

//--- src/clear_counter.sv
`timescale 1ns/1ps

module clear_counter
    import fetch_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   run,
    output logic [bht_index_w-1:0] addr,
    output logic                   done
);

    // sweep address, parked at zero when idle
    always_ff @(posedge clk) begin
        if (rst || !run)
            addr <= '0;
        else
            addr <= addr + 1'b1;
    end

    // last table entry reached
    assign done = run && (addr == bht_index_w'(bht_entries - 1));

endmodule

//--- src/table_ctrl_fsm.sv
`timescale 1ns/1ps

module table_ctrl_fsm (
    input  logic clk,
    input  logic rst,
    input  logic flush,
    input  logic sweep_done,
    output logic clearing,
    output logic queue_flush
);

    typedef enum logic {
        st_sweep,
        st_run
    } state_e;

    state_e state;
    state_e state_nxt;

    // reset lands in sweep so the table starts clean
    always_ff @(posedge clk) begin
        if (rst)
            state <= st_sweep;
        else
            state <= state_nxt;
    end

    always_comb begin
        state_nxt = state;
        case (state)
            st_sweep:
                if (sweep_done)
                    state_nxt = st_run;
            st_run:
                if (flush)
                    state_nxt = st_sweep;
            default: state_nxt = st_sweep;
        endcase
    end

    assign clearing = (state == st_sweep);

    // queue drops on the flush edge and stays empty through the sweep
    assign queue_flush = clearing || (state == st_run && flush);

endmodule

//--- src/fetch_predecode_top.sv
`timescale 1ns/1ps

module fetch_predecode_top
    import fetch_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        push,
    input  fetch_pkt_t  push_pkt,
    input  logic        pop,
    input  logic        flush,
    input  logic        upd_valid,
    input  bht_update_t upd,
    output logic        full,
    output logic        out_valid,
    output predecode_t  out,
    output logic        busy
);

    fetch_pkt_t             head;
    logic                   empty;
    btype_e                 pd_btype;
    logic [bht_index_w-1:0] pd_index;
    logic [31:0]            pd_target;
    bht_entry_t             hist;
    logic                   clearing;
    logic                   queue_flush;
    logic [bht_index_w-1:0] clear_addr;
    logic                   sweep_done;

    assign busy      = clearing;
    assign out_valid = !empty && !busy;

    fetch_fifo fifo_i (
        .clk      (clk),
        .rst      (rst),
        .push     (push),
        .push_pkt (push_pkt),
        .pop      (pop && out_valid),
        .flush    (queue_flush),
        .head     (head),
        .empty    (empty),
        .full     (full)
    );

    fifo_predecoder predecoder_i (
        .pkt    (head),
        .btype  (pd_btype),
        .index  (pd_index),
        .target (pd_target)
    );

    // updates during the sweep are dropped
    branch_history_table bht_i (
        .clk        (clk),
        .rd_index   (pd_index),
        .rd_entry   (hist),
        .wr_en      (upd_valid && !busy),
        .wr         (upd),
        .clearing   (clearing),
        .clear_addr (clear_addr)
    );

    clear_counter counter_i (
        .clk  (clk),
        .rst  (rst),
        .run  (clearing),
        .addr (clear_addr),
        .done (sweep_done)
    );

    table_ctrl_fsm fsm_i (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .sweep_done  (sweep_done),
        .clearing    (clearing),
        .queue_flush (queue_flush)
    );

    // predecode result merged with the table lookup
    always_comb begin
        out.pc          = head.pc;
        out.btype       = pd_btype;
        out.index       = pd_index;
        out.target      = pd_target;
        out.hit         = hist.valid;
        out.hist_btype  = hist.btype;
        out.hist_target = hist.target;
    end

endmodule

//--- verif/fetch_predecode_chk.sv
`timescale 1ns/1ps

module fetch_predecode_chk (
    input logic clk,
    input logic rst,
    input logic flush,
    input logic busy,
    input logic out_valid,
    input logic full,
    input logic empty
);

    int         fail_count = 0;
    logic [8:0] sweep_left;

    // cycles of sweep still owed after an accepted flush
    always_ff @(posedge clk) begin
        if (rst)
            sweep_left <= '0;
        else if (flush && !busy)
            sweep_left <= 9'd256;
        else if (sweep_left != '0)
            sweep_left <= sweep_left - 9'd1;
    end

    // queue stays empty through the sweep, so no output right after it either
    valid_idle: assert property (@(posedge clk) disable iff (rst) busy |=> !out_valid)
        else begin
            $error("out_valid high after a busy cycle");
            fail_count++;
        end

    // one pop per edge, a full queue cannot drain at once without a flush
    full_empty: assert property (@(posedge clk) disable iff (rst) (full && !flush) |=> !empty)
        else begin
            $error("queue went from full to empty in one cycle");
            fail_count++;
        end

    // busy held through the whole sweep
    flush_sweep: assert property (@(posedge clk) disable iff (rst) (sweep_left != '0) |-> busy)
        else begin
            $error("busy fell before the flush sweep ended");
            fail_count++;
        end

endmodule

bind fetch_predecode_top fetch_predecode_chk chk_i (
    .clk       (clk),
    .rst       (rst),
    .flush     (flush),
    .busy      (busy),
    .out_valid (out_valid),
    .full      (full),
    .empty     (empty)
);

//--- verif/fetch_predecode_tb.sv
`timescale 1ns/1ps

module fetch_predecode_tb
    import fetch_pkg::*;
;

    logic        clk = 1'b0;
    logic        rst;
    logic        push;
    fetch_pkt_t  push_pkt;
    logic        pop;
    logic        flush;
    logic        upd_valid;
    bht_update_t upd;
    logic        full;
    logic        out_valid;
    predecode_t  out;
    logic        busy;

    // model state
    fetch_pkt_t  model_q [$];
    bht_entry_t  model_bht [bht_entries];
    int          sweep_left;
    logic        exp_busy;
    logic        exp_valid;
    logic        exp_full;
    predecode_t  exp_out;
    logic [7:0]  trained [6];
    int          n_tests = 0;
    int          n_checks = 0;
    int          n_errors = 0;
    int          errs_before = 0;

    always #10 clk = ~clk;

    fetch_predecode_top fetch_predecode_top_i (.*);

    task automatic check_val(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("CHECK FAILED %s got %h exp %h at %0t", name, got, exp, $time);
        end
    endtask

    function automatic btype_e slot_class(input logic [31:0] w);
        if (w[31:27] == 5'b01010 || w[31:27] == 5'b01001)
            return uncond;
        if (w[31:27] == 5'b01011 || w[31:28] == 4'b0110)
            return pc_rel;
        if (w[31:26] == 6'b010011)
            return indirect;
        return none;
    endfunction

    // expected predecode fields, table part left at zero
    function automatic predecode_t predict(input fetch_pkt_t p);
        predecode_t  r;
        btype_e      c1;
        logic        slot;
        logic [31:0] w;
        logic [31:0] offs;
        r = '0;
        c1 = slot_class(p.inst1.raw);
        slot = (c1 != none);
        w = slot ? p.inst1.raw : p.inst0.raw;
        r.pc = p.pc;
        r.index = {p.pc[19], p.pc[16:12], p.pc[5:4]};
        if (slot)
            r.btype = c1;
        else if (!p.pc[2] && slot_class(p.inst0.raw) == indirect)
            r.btype = indirect;
        else
            r.btype = none;
        // long form keeps the low ten bits above offs16
        if (w[31:27] == 5'b01010)
            offs = {{4{w[9]}}, w[9:0], w[25:10], 2'b00};
        else
            offs = {{14{w[25]}}, w[25:10], 2'b00};
        if (r.btype == uncond || r.btype == pc_rel)
            r.target = {p.pc[31:3], slot, 2'b00} + offs;
        return r;
    endfunction

    function automatic void clear_model_bht();
        foreach (model_bht[i])
            model_bht[i] = '0;
    endfunction

    // outputs and inputs both settled at the falling edge
    always @(negedge clk) begin
        if (rst) begin
            model_q.delete();
            clear_model_bht();
            sweep_left = 256;
        end else begin
            exp_busy = (sweep_left != 0);
            exp_valid = (model_q.size() != 0) && !exp_busy;
            exp_full = (model_q.size() == fifo_depth);
            check_val("busy", busy, exp_busy);
            check_val("out_valid", out_valid, exp_valid);
            check_val("full", full, exp_full);
            if (exp_valid) begin
                exp_out = predict(model_q[0]);
                exp_out.hit = model_bht[exp_out.index].valid;
                exp_out.hist_btype = model_bht[exp_out.index].btype;
                exp_out.hist_target = model_bht[exp_out.index].target;
                check_val("out", out, exp_out);
            end
            // effect of the coming rising edge
            if (exp_busy) begin
                sweep_left--;
                model_q.delete();
            end else if (flush) begin
                sweep_left = 256;
                model_q.delete();
                clear_model_bht();
            end else begin
                if (upd_valid)
                    model_bht[upd.index] = '{1'b1, upd.btype, upd.target};
                // full taken before the pop so a push on a full queue is lost
                if (pop && model_q.size() != 0)
                    void'(model_q.pop_front());
                if (push && !exp_full)
                    model_q.push_back(push_pkt);
            end
        end
    end

    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    function automatic logic cond_met(input string what);
        if (what == "busy low")
            return !busy;
        else if (what == "out_valid")
            return out_valid;
        else if (what == "queue space")
            return !full;
        return !out_valid;
    endfunction

    task automatic wait_until(input string what, input int limit);
        int n;
        n = 0;
        while (!cond_met(what) && n < limit) begin
            tick();
            n++;
        end
        if (!cond_met(what)) begin
            $display("timeout after %0d cycles waiting for %s", limit, what);
            $display("TESTBENCH FAILED");
            $finish;
        end
    endtask

    // k picks an opcode prefix, 5 a non-branch, above that fully random
    function automatic logic [31:0] make_word(input int k);
        logic [31:0] r;
        r = $urandom;
        case (k)
            0: r[31:27] = 5'b01010;
            1: r[31:27] = 5'b01001;
            2: r[31:27] = 5'b01011;
            3: r[31:28] = 4'b0110;
            4: r[31:26] = 6'b010011;
            5: r[31:29] = 3'b111;
            default: r = r;
        endcase
        return r;
    endfunction

    function automatic logic [31:0] pc_for(input logic [7:0] idx);
        logic [31:0] p;
        p = $urandom;
        p[19] = idx[7];
        p[16:12] = idx[6:2];
        p[5:4] = idx[1:0];
        return p;
    endfunction

    task automatic send_pkt(input fetch_pkt_t p);
        wait_until("queue space", 50);
        push = 1'b1;
        push_pkt = p;
        tick();
        push = 1'b0;
    endtask

    task automatic take_pkt();
        wait_until("out_valid", 50);
        pop = 1'b1;
        tick();
        pop = 1'b0;
    endtask

    task automatic send_update(input logic [7:0] idx);
        upd_valid = 1'b1;
        upd.index = idx;
        upd.btype = btype_e'(2'($urandom));
        upd.target = $urandom;
        tick();
        upd_valid = 1'b0;
    endtask

    task automatic end_test(input string name);
        n_tests++;
        $display("test %-16s done, %0d errors", name, n_errors - errs_before);
        errs_before = n_errors;
    endtask

    initial begin
        fetch_pkt_t pkt;
        void'($urandom(32'h25c9));
        rst = 1'b1;
        push = 1'b0;
        push_pkt = '0;
        pop = 1'b0;
        flush = 1'b0;
        upd_valid = 1'b0;
        upd = '0;
        repeat (4) tick();
        rst = 1'b0;
        wait_until("busy low", 300);
        end_test("reset_sweep");

        // every prefix in each slot, pc bit 2 both ways
        for (int s = 0; s < 2; s++) begin
            for (int k = 0; k < 6; k++) begin
                for (int b = 0; b < 2; b++) begin
                    pkt.pc = $urandom;
                    pkt.pc[2] = b[0];
                    pkt.inst0.raw = make_word(s == 0 ? k : 5);
                    pkt.inst1.raw = make_word(s == 1 ? k : 5);
                    send_pkt(pkt);
                    take_pkt();
                end
            end
        end
        end_test("classification");

        // pushes outpace pops so the queue fills and drops
        repeat (300) begin
            push = ($urandom % 4) != 0;
            pop = ($urandom % 2) == 0;
            push_pkt.pc = $urandom;
            push_pkt.inst0.raw = make_word($urandom % 7);
            push_pkt.inst1.raw = make_word($urandom % 7);
            tick();
        end
        push = 1'b0;
        pop = 1'b1;
        wait_until("drained", 20);
        pop = 1'b0;
        end_test("random_traffic");

        foreach (trained[i]) begin
            trained[i] = 8'($urandom);
            send_update(trained[i]);
        end
        foreach (trained[i]) begin
            pkt.pc = pc_for(trained[i]);
            pkt.inst0.raw = make_word($urandom % 7);
            pkt.inst1.raw = make_word($urandom % 7);
            send_pkt(pkt);
            take_pkt();
            pkt.pc = pc_for(trained[i] ^ 8'h5a);
            send_pkt(pkt);
            take_pkt();
        end
        end_test("training");

        // queued packets and a mid-sweep update must vanish
        send_pkt(pkt);
        send_pkt(pkt);
        flush = 1'b1;
        tick();
        flush = 1'b0;
        send_update(trained[0]);
        // pushes through the whole sweep are dropped as well
        push = 1'b1;
        wait_until("busy low", 300);
        push = 1'b0;
        foreach (trained[i]) begin
            pkt.pc = pc_for(trained[i]);
            send_pkt(pkt);
            take_pkt();
        end
        end_test("flush");

        $display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
                 n_tests, n_checks, n_errors, fetch_predecode_top_i.chk_i.fail_count);
        if (n_errors == 0 && fetch_predecode_top_i.chk_i.fail_count == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

//--- compile.f
src/fetch_pkg.sv
src/fetch_fifo.sv
src/fifo_predecoder.sv
src/branch_history_table.sv
src/clear_counter.sv
src/table_ctrl_fsm.sv
src/fetch_predecode_top.sv
verif/fetch_predecode_chk.sv
verif/fetch_predecode_tb.sv

//--- Makefile
TOP = fetch_predecode_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module $(TOP)

run: build
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "TESTBENCH PASSED"

lint:
	verilator --lint-only --timing -Wall -f compile.f --top-module $(TOP)

clean:
	rm -rf obj_dir
